// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module exe_tb -f vlog.f -o sim_exe
	./obj_dir/sim_exe > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== common/es_ms_if.sv ====
interface es_ms_if;
    import exe_pkg::*;

    logic            valid;     // execute has a finished instruction
    logic            allowin;   // memory stage can take it
    logic [XLEN-1:0] pc;
    mem_op_t         mem_op;
    logic            mem_req;   // a data_ok will follow for this one
    logic            ale;
    logic [XLEN-1:0] result;    // address for memory ops
    logic            rf_we;
    logic [4:0]      rf_waddr;

    modport exe (
        output valid, pc, mem_op, mem_req, ale, result, rf_we, rf_waddr,
        input  allowin
    );

    modport mem (
        input  valid, pc, mem_op, mem_req, ale, result, rf_we, rf_waddr,
        output allowin
    );

endinterface

// ==== common/exe_pkg.sv ====
package exe_pkg;

    localparam int XLEN = 32;   // data and address width

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_MUL  = 4'd10    // iterative, low half of product
    } alu_op_t;

    typedef enum logic [3:0] {
        MEM_NONE  = 4'd0,
        MEM_LD_B  = 4'd1,
        MEM_LD_BU = 4'd2,
        MEM_LD_H  = 4'd3,
        MEM_LD_HU = 4'd4,
        MEM_LD_W  = 4'd5,
        MEM_ST_B  = 4'd6,
        MEM_ST_H  = 4'd7,
        MEM_ST_W  = 4'd8
    } mem_op_t;

    // where the execute result comes from
    typedef enum logic [1:0] {
        CNT_ALU = 2'd0,
        CNT_LO  = 2'd1,
        CNT_HI  = 2'd2
    } cnt_sel_t;

    localparam logic [5:0] ECODE_NONE = 6'h00;
    localparam logic [5:0] ECODE_ALE  = 6'h09;  // address misaligned

    function automatic logic is_load(mem_op_t op);
        return op inside {MEM_LD_B, MEM_LD_BU, MEM_LD_H, MEM_LD_HU, MEM_LD_W};
    endfunction

    function automatic logic is_store(mem_op_t op);
        return op inside {MEM_ST_B, MEM_ST_H, MEM_ST_W};
    endfunction

    // sram size encoding: 0 byte, 1 half, 2 word
    function automatic logic [1:0] mem_size(mem_op_t op);
        if (op inside {MEM_LD_B, MEM_LD_BU, MEM_ST_B})
            return 2'd0;
        if (op inside {MEM_LD_H, MEM_LD_HU, MEM_ST_H})
            return 2'd1;
        return 2'd2;
    endfunction

endpackage

// ==== exe/alu.sv ====
module alu #(
    parameter int MUL_CYCLES = 4
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     start,
    input  exe_pkg::alu_op_t         alu_op,
    input  logic [exe_pkg::XLEN-1:0] src1,
    input  logic [exe_pkg::XLEN-1:0] src2,
    output logic [exe_pkg::XLEN-1:0] result,
    output logic                     complete
);
    import exe_pkg::*;

    localparam int CHUNK = (XLEN + MUL_CYCLES - 1) / MUL_CYCLES;   // multiplier bits per step
    localparam int PADW  = CHUNK * MUL_CYCLES;
    localparam int SW    = $clog2(MUL_CYCLES + 1);

    logic [SW-1:0]   step;
    logic            mul_done;
    logic [PADW-1:0] mplier;
    logic [XLEN-1:0] acc;
    logic [XLEN-1:0] acc_next;

    assign mul_done = (step == SW'(MUL_CYCLES));
    assign mplier   = PADW'(src2);

    // shift-add over one chunk of the multiplier
    always_comb begin
        int base;
        base     = int'(step) * CHUNK;
        acc_next = acc;
        for (int i = 0; i < CHUNK; i++) begin
            if (base + i < PADW && mplier[base + i])
                acc_next = acc_next + (src1 << (base + i));
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            step <= '0;
        else if (start)
            step <= '0;     // new instruction restarts the iteration
        else if (!mul_done)
            step <= step + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (start)
            acc <= '0;
        else if (!mul_done)
            acc <= acc_next;
    end

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = src1 + src2;
            ALU_SUB:  result = src1 - src2;
            ALU_AND:  result = src1 & src2;
            ALU_OR:   result = src1 | src2;
            ALU_XOR:  result = src1 ^ src2;
            ALU_SLL:  result = src1 << src2[4:0];
            ALU_SRL:  result = src1 >> src2[4:0];
            ALU_SRA:  result = $signed(src1) >>> src2[4:0];
            ALU_SLT:  result = XLEN'($signed(src1) < $signed(src2));
            ALU_SLTU: result = XLEN'(src1 < src2);
            ALU_MUL:  result = acc;
            default:  result = '0;
        endcase
    end

    assign complete = (alu_op != ALU_MUL) | mul_done;

endmodule

// ==== exe/exe_stage.sv ====
module exe_stage #(
    parameter int MUL_CYCLES = 4
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     flush,
    input  logic [63:0]              counter,
    input  logic                     ds2es_valid,
    input  logic [exe_pkg::XLEN-1:0] ds2es_pc,
    input  exe_pkg::alu_op_t         ds2es_alu_op,
    input  logic [exe_pkg::XLEN-1:0] ds2es_src1,
    input  logic [exe_pkg::XLEN-1:0] ds2es_src2,
    input  logic [exe_pkg::XLEN-1:0] ds2es_store_data,
    input  exe_pkg::mem_op_t         ds2es_mem_op,
    input  exe_pkg::cnt_sel_t        ds2es_cnt_sel,
    input  logic                     ds2es_rf_we,
    input  logic [4:0]               ds2es_rf_waddr,
    output logic                     es_allowin,
    output logic                     req,
    output logic                     wr,
    output logic [1:0]               size,
    output logic [3:0]               wstrb,
    output logic [exe_pkg::XLEN-1:0] addr,
    output logic [exe_pkg::XLEN-1:0] wdata,
    input  logic                     addr_ok,
    es_ms_if.exe                     es2ms
);
    import exe_pkg::*;

    logic            es_valid;
    logic            es_ready_go;
    logic [XLEN-1:0] es_pc;
    alu_op_t         es_alu_op;
    logic [XLEN-1:0] es_src1;
    logic [XLEN-1:0] es_src2;
    logic [XLEN-1:0] es_store_data;
    mem_op_t         es_mem_op;
    cnt_sel_t        es_cnt_sel;
    logic            es_rf_we;
    logic [4:0]      es_rf_waddr;
    logic            alu_start;
    logic [XLEN-1:0] alu_result;
    logic            alu_complete;
    logic            es_is_mem;
    logic [XLEN-1:0] mem_addr;
    logic [1:0]      mem_size_q;
    logic            es_ale;
    logic            need_req;
    logic [3:0]      byte_en;
    logic [XLEN-1:0] exe_result;

    assign alu_start   = ds2es_valid & es_allowin;
    assign es_ready_go = alu_complete & (~need_req | req & addr_ok);
    assign es_allowin  = ~es_valid | es_ready_go & es2ms.allowin;

    always_ff @(posedge clk) begin
        if (!resetn)
            es_valid <= 1'b0;
        else if (flush)
            es_valid <= 1'b0;   // younger than the excepting instruction
        else if (es_allowin)
            es_valid <= ds2es_valid;
    end

    always_ff @(posedge clk) begin
        if (alu_start) begin
            es_pc         <= ds2es_pc;
            es_alu_op     <= ds2es_alu_op;
            es_src1       <= ds2es_src1;
            es_src2       <= ds2es_src2;
            es_store_data <= ds2es_store_data;
            es_mem_op     <= ds2es_mem_op;
            es_cnt_sel    <= ds2es_cnt_sel;
            es_rf_we      <= ds2es_rf_we;
            es_rf_waddr   <= ds2es_rf_waddr;
        end
    end

    alu #(
        .MUL_CYCLES (MUL_CYCLES)
    ) u_alu (
        .clk      (clk),
        .resetn   (resetn),
        .start    (alu_start),
        .alu_op   (es_alu_op),
        .src1     (es_src1),
        .src2     (es_src2),
        .result   (alu_result),
        .complete (alu_complete)
    );

    // own adder so the address does not depend on alu_op
    assign es_is_mem  = es_mem_op != MEM_NONE;
    assign mem_addr   = es_src1 + es_src2;
    assign mem_size_q = mem_size(es_mem_op);
    assign es_ale     = es_is_mem & ((mem_size_q == 2'd2) & (|mem_addr[1:0]) |
                                     (mem_size_q == 2'd1) & mem_addr[0]);
    assign need_req   = es_valid & es_is_mem & ~es_ale;

    always_comb begin
        case (mem_size_q)
            2'd0:    byte_en = 4'b0001 << mem_addr[1:0];
            2'd1:    byte_en = mem_addr[1] ? 4'b1100 : 4'b0011;
            default: byte_en = 4'b1111;
        endcase
    end

    // new requests only when the memory stage can take the instruction
    assign req   = need_req & es2ms.allowin & ~flush;
    assign wr    = req & is_store(es_mem_op);
    assign size  = mem_size_q;
    assign wstrb = {4{wr}} & byte_en;
    assign addr  = mem_addr;

    always_comb begin
        case (mem_size_q)
            2'd0:    wdata = {4{es_store_data[7:0]}};   // byte lane replicated
            2'd1:    wdata = {2{es_store_data[15:0]}};
            default: wdata = es_store_data;
        endcase
    end

    always_comb begin
        case (es_cnt_sel)
            CNT_LO:  exe_result = counter[31:0];
            CNT_HI:  exe_result = counter[63:32];
            default: exe_result = alu_result;
        endcase
    end

    assign es2ms.valid    = es_valid & es_ready_go;
    assign es2ms.pc       = es_pc;
    assign es2ms.mem_op   = es_mem_op;
    assign es2ms.mem_req  = need_req;
    assign es2ms.ale      = es_ale;
    assign es2ms.result   = es_is_mem ? mem_addr : exe_result;
    assign es2ms.rf_we    = es_rf_we;
    assign es2ms.rf_waddr = es_rf_waddr;

endmodule

// ==== rtl/csr_block.sv ====
module csr_block (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     retire_ex,
    input  logic [exe_pkg::XLEN-1:0] retire_pc,
    input  logic [exe_pkg::XLEN-1:0] retire_badv,
    output logic                     flush,
    output logic [63:0]              counter,
    output logic [5:0]               cause,
    output logic [exe_pkg::XLEN-1:0] badv
);
    import exe_pkg::*;

    // stable counter, free running from reset
    always_ff @(posedge clk) begin
        if (!resetn)
            counter <= '0;
        else
            counter <= counter + 64'd1;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            flush <= 1'b0;
            cause <= ECODE_NONE;
            badv  <= '0;
        end else begin
            flush <= retire_ex;     // single cycle pulse
            if (retire_ex) begin
                cause <= ECODE_ALE;  // only exception source here
                badv  <= retire_badv;
            end
        end
    end

endmodule

// ==== rtl/exe_top.sv ====
module exe_top #(
    parameter int MUL_CYCLES = 4
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     ds2es_valid,
    input  logic [exe_pkg::XLEN-1:0] ds2es_pc,
    input  exe_pkg::alu_op_t         ds2es_alu_op,
    input  logic [exe_pkg::XLEN-1:0] ds2es_src1,
    input  logic [exe_pkg::XLEN-1:0] ds2es_src2,
    input  logic [exe_pkg::XLEN-1:0] ds2es_store_data,
    input  exe_pkg::mem_op_t         ds2es_mem_op,
    input  exe_pkg::cnt_sel_t        ds2es_cnt_sel,
    input  logic                     ds2es_rf_we,
    input  logic [4:0]               ds2es_rf_waddr,
    output logic                     es_allowin,
    output logic                     data_sram_req,
    output logic                     data_sram_wr,
    output logic [1:0]               data_sram_size,
    output logic [3:0]               data_sram_wstrb,
    output logic [exe_pkg::XLEN-1:0] data_sram_addr,
    output logic [exe_pkg::XLEN-1:0] data_sram_wdata,
    input  logic                     data_sram_addr_ok,
    input  logic                     data_sram_data_ok,
    input  logic [exe_pkg::XLEN-1:0] data_sram_rdata,
    output logic                     ws_valid,
    input  logic                     ws_allowin,
    output logic [exe_pkg::XLEN-1:0] ws_pc,
    output logic                     ws_rf_we,
    output logic [4:0]               ws_rf_waddr,
    output logic [exe_pkg::XLEN-1:0] ws_rf_wdata,
    output logic                     ws_ex,
    output logic [5:0]               ex_cause,
    output logic [exe_pkg::XLEN-1:0] ex_badv
);
    import exe_pkg::*;

    logic            flush;
    logic [63:0]     counter;
    logic            retire_ex;
    logic [XLEN-1:0] retire_pc;
    logic [XLEN-1:0] retire_badv;

    es_ms_if es2ms ();

    exe_stage #(
        .MUL_CYCLES (MUL_CYCLES)
    ) u_exe_stage (
        .clk              (clk),
        .resetn           (resetn),
        .flush            (flush),
        .counter          (counter),
        .ds2es_valid      (ds2es_valid),
        .ds2es_pc         (ds2es_pc),
        .ds2es_alu_op     (ds2es_alu_op),
        .ds2es_src1       (ds2es_src1),
        .ds2es_src2       (ds2es_src2),
        .ds2es_store_data (ds2es_store_data),
        .ds2es_mem_op     (ds2es_mem_op),
        .ds2es_cnt_sel    (ds2es_cnt_sel),
        .ds2es_rf_we      (ds2es_rf_we),
        .ds2es_rf_waddr   (ds2es_rf_waddr),
        .es_allowin       (es_allowin),
        .req              (data_sram_req),
        .wr               (data_sram_wr),
        .size             (data_sram_size),
        .wstrb            (data_sram_wstrb),
        .addr             (data_sram_addr),
        .wdata            (data_sram_wdata),
        .addr_ok          (data_sram_addr_ok),
        .es2ms            (es2ms.exe)
    );

    mem_stage u_mem_stage (
        .clk               (clk),
        .resetn            (resetn),
        .flush             (flush),
        .es2ms             (es2ms.mem),
        .data_sram_data_ok (data_sram_data_ok),
        .data_sram_rdata   (data_sram_rdata),
        .ws_valid          (ws_valid),
        .ws_allowin        (ws_allowin),
        .ws_pc             (ws_pc),
        .ws_rf_we          (ws_rf_we),
        .ws_rf_waddr       (ws_rf_waddr),
        .ws_rf_wdata       (ws_rf_wdata),
        .ws_ex             (ws_ex),
        .retire_ex         (retire_ex),
        .retire_pc         (retire_pc),
        .retire_badv       (retire_badv)
    );

    csr_block u_csr_block (
        .clk         (clk),
        .resetn      (resetn),
        .retire_ex   (retire_ex),
        .retire_pc   (retire_pc),
        .retire_badv (retire_badv),
        .flush       (flush),
        .counter     (counter),
        .cause       (ex_cause),
        .badv        (ex_badv)
    );

endmodule

// ==== rtl/mem_stage.sv ====
module mem_stage (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     flush,
    es_ms_if.mem                     es2ms,
    input  logic                     data_sram_data_ok,
    input  logic [exe_pkg::XLEN-1:0] data_sram_rdata,
    output logic                     ws_valid,
    input  logic                     ws_allowin,
    output logic [exe_pkg::XLEN-1:0] ws_pc,
    output logic                     ws_rf_we,
    output logic [4:0]               ws_rf_waddr,
    output logic [exe_pkg::XLEN-1:0] ws_rf_wdata,
    output logic                     ws_ex,
    output logic                     retire_ex,
    output logic [exe_pkg::XLEN-1:0] retire_pc,
    output logic [exe_pkg::XLEN-1:0] retire_badv
);
    import exe_pkg::*;

    logic            ms_valid;
    logic            wait_data;     // one response outstanding, possibly orphaned
    logic [XLEN-1:0] ms_pc;
    mem_op_t         ms_mem_op;
    logic            ms_ale;
    logic [XLEN-1:0] ms_result;
    logic            ms_rf_we;
    logic [4:0]      ms_rf_waddr;
    logic [XLEN-1:0] ms_rdata;
    logic [7:0]      ld_byte;
    logic [15:0]     ld_half;
    logic [XLEN-1:0] ld_value;

    // an excepting instruction blocks entry until it has retired
    assign es2ms.allowin = ~wait_data & (~ms_valid | ws_allowin & ~ms_ale);

    always_ff @(posedge clk) begin
        if (!resetn)
            ms_valid <= 1'b0;
        else if (flush)
            ms_valid <= 1'b0;
        else if (retire_ex)
            ms_valid <= 1'b0;   // younger ones wait for the flush
        else if (es2ms.allowin)
            ms_valid <= es2ms.valid;
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            wait_data <= 1'b0;
        else if (es2ms.valid && es2ms.allowin && es2ms.mem_req)
            wait_data <= 1'b1;
        else if (data_sram_data_ok)
            wait_data <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (es2ms.valid && es2ms.allowin) begin
            ms_pc       <= es2ms.pc;
            ms_mem_op   <= es2ms.mem_op;
            ms_ale      <= es2ms.ale;
            ms_result   <= es2ms.result;
            ms_rf_we    <= es2ms.rf_we;
            ms_rf_waddr <= es2ms.rf_waddr;
        end
        if (data_sram_data_ok && wait_data)
            ms_rdata <= data_sram_rdata;    // held while retire is stalled
    end

    assign ld_byte = ms_rdata[{ms_result[1:0], 3'b000} +: 8];
    assign ld_half = ms_result[1] ? ms_rdata[31:16] : ms_rdata[15:0];

    always_comb begin
        case (ms_mem_op)
            MEM_LD_B:  ld_value = {{(XLEN-8){ld_byte[7]}}, ld_byte};
            MEM_LD_BU: ld_value = {{(XLEN-8){1'b0}}, ld_byte};
            MEM_LD_H:  ld_value = {{(XLEN-16){ld_half[15]}}, ld_half};
            MEM_LD_HU: ld_value = {{(XLEN-16){1'b0}}, ld_half};
            default:   ld_value = ms_rdata;
        endcase
    end

    assign ws_valid    = ms_valid & ~wait_data;
    assign ws_pc       = ms_pc;
    assign ws_ex       = ms_valid & ms_ale;
    assign ws_rf_we    = ms_rf_we & ~ms_ale;
    assign ws_rf_waddr = ms_rf_waddr;
    assign ws_rf_wdata = is_load(ms_mem_op) ? ld_value : ms_result;

    assign retire_ex   = ws_valid & ws_allowin & ws_ex;
    assign retire_pc   = ms_pc;
    assign retire_badv = ms_result;     // the faulting address

endmodule

// ==== testbench/exe_assertions.sv ====
module exe_assertions (
    input logic       clk,
    input logic       resetn,
    input logic       flush,
    input logic       req,
    input logic       wr,
    input logic [1:0] size,
    input logic [3:0] wstrb,
    input logic       addr_ok,
    input logic       ms_allowin,
    input logic       es_allowin
);

    // a pending request is only withdrawn by a flush or a stalled memory stage
    property req_held;
        @(posedge clk) disable iff (!resetn)
            req && !addr_ok |=> req || flush || !ms_allowin;
    endproperty

    // strobes only on writes, one per byte of the access size
    property strobe_matches_size;
        @(posedge clk) disable iff (!resetn)
            wr ? ($countones(wstrb) == (32'd1 << size)) : (wstrb == 4'b0000);
    endproperty

    property allowin_after_reset;
        @(posedge clk) $rose(resetn) |-> es_allowin;
    endproperty

    a_req_held:       assert property (req_held) else $error("req dropped before addr_ok");
    a_strobe:         assert property (strobe_matches_size)
                          else $error("wstrb does not match wr and size");
    a_allowin_reset:  assert property (allowin_after_reset) else $error("es_allowin low after reset");

endmodule

bind exe_stage exe_assertions u_exe_assertions (
    .clk        (clk),
    .resetn     (resetn),
    .flush      (flush),
    .req        (req),
    .wr         (wr),
    .size       (size),
    .wstrb      (wstrb),
    .addr_ok    (addr_ok),
    .ms_allowin (es2ms.allowin),
    .es_allowin (es_allowin)
);

// ==== testbench/exe_tb.sv ====
module exe_tb;
    import exe_pkg::*;

    localparam int MAX_CYCLES = 4000;   // all tests together run for about a thousand cycles

    typedef struct packed {
        logic [31:0] pc;
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] data;
        logic        ex;
        logic        chk;       // data known in advance
    } rec_t;

    logic clk, resetn;
    logic ds2es_valid, ds2es_rf_we, es_allowin;
    logic [31:0] ds2es_pc, ds2es_src1, ds2es_src2, ds2es_store_data;
    alu_op_t ds2es_alu_op;
    mem_op_t ds2es_mem_op;
    cnt_sel_t ds2es_cnt_sel;
    logic [4:0] ds2es_rf_waddr, ws_rf_waddr;
    logic data_sram_req, data_sram_wr, data_sram_addr_ok, data_sram_data_ok;
    logic [1:0] data_sram_size;
    logic [3:0] data_sram_wstrb;
    logic [31:0] data_sram_addr, data_sram_wdata, data_sram_rdata;
    logic ws_valid, ws_allowin, ws_rf_we, ws_ex;
    logic [31:0] ws_pc, ws_rf_wdata, ex_badv;
    logic [5:0] ex_cause;

    integer seed = 32'hd2627894;
    int cycle, errors, checks, tests, test_errors;
    string test_name;
    logic [31:0] next_pc;
    bit bp_mode;
    int stall_left;
    logic [31:0] ram [0:255];       // memory seen by the DUT
    logic [7:0] model_b [0:1023];   // expected memory contents
    int resp_due[$];
    logic [31:0] resp_data[$];
    logic [34:0] req_exp[$];        // {wr, size, addr} of each request to come
    rec_t exp_q[$], ret_q[$];
    logic [31:0] drained[$];

    exe_top #(.MUL_CYCLES(4)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // memory model: random addr_ok, in-order data_ok 1 to 3 cycles later
    always @(posedge clk) begin
        #1;
        data_sram_addr_ok = bp_mode ? ($random(seed) & 3) == 0 : $random(seed) & 1;
        data_sram_data_ok = 1'b0;
        if (resp_due.size() > 0 && resp_due[0] <= cycle) begin
            void'(resp_due.pop_front());
            data_sram_data_ok = 1'b1;
            data_sram_rdata = resp_data.pop_front();
        end
        if (!bp_mode)
            ws_allowin = 1'b1;
        else if (stall_left > 0) begin
            ws_allowin = 1'b0;
            stall_left--;
        end else begin
            ws_allowin = 1'b1;
            if (($random(seed) & 3) == 0)
                stall_left = 1 + ($random(seed) & 3);
        end
    end

    always @(negedge clk) begin
        int due;
        logic [34:0] req_next;
        if (resetn && data_sram_req && data_sram_addr_ok) begin
            if (req_exp.size() == 0) begin
                errors++;
                $display("error %s: memory request issued when none was expected", test_name);
            end else begin
                req_next = req_exp.pop_front();
                check("request wr", req_next[34], data_sram_wr);
                check("request size", req_next[33:32], data_sram_size);
                check("request addr", req_next[31:0], data_sram_addr);
            end
            for (int k = 0; k < 4; k++)
                if (data_sram_wr && data_sram_wstrb[k])
                    ram[data_sram_addr[9:2]][8*k +: 8] = data_sram_wdata[8*k +: 8];
            due = cycle + 1 + (($random(seed) & 32'h7fff_ffff) % 3);
            if (resp_due.size() > 0 && due <= resp_due[$])
                due = resp_due[$] + 1;
            resp_due.push_back(due);
            resp_data.push_back(ram[data_sram_addr[9:2]]);
        end
        if (resetn && ws_valid && ws_allowin)
            ret_q.push_back('{ws_pc, ws_rf_we, ws_rf_waddr, ws_rf_wdata, ws_ex, 1'b1});
    end

    task automatic check(string what, logic [63:0] expected, logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error %s: %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    function automatic logic [31:0] alu_model(alu_op_t op, logic [31:0] a, logic [31:0] b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: return {31'b0, a < b};
            default:  return a * b;
        endcase
    endfunction

    function automatic logic [31:0] load_model(mem_op_t op, logic [9:0] a);
        case (op)
            MEM_LD_B:  return {{24{model_b[a][7]}}, model_b[a]};
            MEM_LD_BU: return {24'b0, model_b[a]};
            MEM_LD_H:  return {{16{model_b[a+1][7]}}, model_b[a+1], model_b[a]};
            MEM_LD_HU: return {16'b0, model_b[a+1], model_b[a]};
            default:   return {model_b[a+3], model_b[a+2], model_b[a+1], model_b[a]};
        endcase
    endfunction

    // call and return 1 time unit after a rising edge
    task automatic send(alu_op_t op, logic [31:0] a, logic [31:0] b, logic [31:0] sd,
                        mem_op_t mop, cnt_sel_t cs, logic we, logic [4:0] wa);
        ds2es_valid = 1'b1;
        ds2es_pc = next_pc;
        ds2es_alu_op = op;
        ds2es_src1 = a;
        ds2es_src2 = b;
        ds2es_store_data = sd;
        ds2es_mem_op = mop;
        ds2es_cnt_sel = cs;
        ds2es_rf_we = we;
        ds2es_rf_waddr = wa;
        @(negedge clk);
        while (!es_allowin)
            @(negedge clk);
        @(posedge clk);
        #1;
        ds2es_valid = 1'b0;
        next_pc += 4;
    endtask

    task automatic do_alu(alu_op_t op, logic [31:0] a, logic [31:0] b, logic [4:0] wa,
                          bit expected);
        if (expected)
            exp_q.push_back('{next_pc, 1'b1, wa, alu_model(op, a, b), 1'b0, 1'b1});
        send(op, a, b, 32'h0, MEM_NONE, CNT_ALU, 1'b1, wa);
    endtask

    task automatic do_mem(mem_op_t mop, logic [31:0] a, logic [31:0] d, logic [4:0] wa,
                          bit expected);
        logic st, bad;
        logic [1:0] sz;
        st = mop inside {MEM_ST_B, MEM_ST_H, MEM_ST_W};
        bad = (mop inside {MEM_LD_W, MEM_ST_W} && a[1:0] != 2'b00) ||
              (mop inside {MEM_LD_H, MEM_LD_HU, MEM_ST_H} && a[0]);
        if (mop inside {MEM_LD_B, MEM_LD_BU, MEM_ST_B})
            sz = 2'd0;      // byte
        else if (mop inside {MEM_LD_H, MEM_LD_HU, MEM_ST_H})
            sz = 2'd1;
        else
            sz = 2'd2;
        if (expected) begin
            exp_q.push_back('{next_pc, !st && !bad, wa, load_model(mop, a[9:0]), bad, 1'b1});
            if (!bad)
                req_exp.push_back({st, sz, a});
            if (st && !bad) begin
                model_b[a[9:0]] = d[7:0];
                if (mop != MEM_ST_B)
                    {model_b[a[9:0]+1]} = d[15:8];
                if (mop == MEM_ST_W)
                    {model_b[a[9:0]+3], model_b[a[9:0]+2]} = d[31:16];
            end
        end
        send(ALU_ADD, a & ~32'hf, a & 32'hf, d, mop, CNT_ALU, !st, wa);
    endtask

    // wait for every expected retire, then for the pipeline to go quiet
    task automatic drain();
        int idle;
        idle = 0;
        while (ret_q.size() < exp_q.size() || idle < 4) begin
            @(negedge clk);
            if (es_allowin && !ws_valid && !data_sram_req && resp_due.size() == 0)
                idle++;
            else
                idle = 0;
        end
        @(posedge clk);
        #1;
        check("retire count", exp_q.size(), ret_q.size());
        drained.delete();
        foreach (exp_q[i]) begin
            if (i < ret_q.size()) begin
                check("pc", exp_q[i].pc, ret_q[i].pc);
                check("ws_ex", exp_q[i].ex, ret_q[i].ex);
                check("rf_we", exp_q[i].we, ret_q[i].we);
                if (exp_q[i].we)
                    check("rf_waddr", exp_q[i].waddr, ret_q[i].waddr);
                if (exp_q[i].we && exp_q[i].chk)
                    check("rf_wdata", exp_q[i].data, ret_q[i].data);
                drained.push_back(ret_q[i].data);
            end
        end
        exp_q.delete();
        ret_q.delete();
    endtask

    task automatic memory_matches();
        for (int w = 0; w < 256; w++)
            check("memory word", {model_b[4*w+3], model_b[4*w+2], model_b[4*w+1], model_b[4*w]},
                  ram[w]);
    endtask

    task automatic end_test();
        tests++;
        $display("test %s: %s", test_name, errors == test_errors ? "ok" : "failed");
        test_errors = errors;
    endtask

    task automatic alu_test();
        test_name = "alu";
        for (int i = 0; i <= 10; i++)
            do_alu(alu_op_t'(i), 32'h8000_1234, 32'h0000_0013, 5'(i + 1), 1'b1);
        for (int i = 0; i < 3; i++)
            do_alu(ALU_MUL, $random(seed), $random(seed), 5'd20 + 5'(i), 1'b1);
        drain();
        end_test();
    endtask

    task automatic store_load_test();
        test_name = "store_load";
        for (int k = 0; k < 4; k++)
            do_mem(MEM_ST_B, 32'h200 + k, 32'h80 + 32'(k * 17), 5'd0, 1'b1);
        do_mem(MEM_ST_H, 32'h210, 32'h0000_8a5c, 5'd0, 1'b1);
        do_mem(MEM_ST_H, 32'h212, 32'h0000_13f7, 5'd0, 1'b1);
        do_mem(MEM_ST_W, 32'h220, 32'hdead_b00f, 5'd0, 1'b1);
        for (int a = 32'h200; a < 32'h224; a++) begin
            do_mem(MEM_LD_B, a, 0, 5'd3, 1'b1);
            do_mem(MEM_LD_BU, a, 0, 5'd4, 1'b1);
            if (a[0] == 1'b0) begin
                do_mem(MEM_LD_H, a, 0, 5'd5, 1'b1);
                do_mem(MEM_LD_HU, a, 0, 5'd6, 1'b1);
            end
            if (a[1:0] == 2'b00)
                do_mem(MEM_LD_W, a, 0, 5'd7, 1'b1);
        end
        drain();
        memory_matches();
        end_test();
    endtask

    task automatic misalign_test();
        test_name = "misalign";
        do_mem(MEM_LD_W, 32'h102, 0, 5'd8, 1'b1);
        do_alu(ALU_ADD, 32'd1, 32'd2, 5'd9, 1'b0);      // younger, flushed
        drain();
        check("ex_cause", ECODE_ALE, ex_cause);
        check("ex_badv", 32'h102, ex_badv);
        do_mem(MEM_ST_H, 32'h41, 32'h5555_aaaa, 5'd0, 1'b1);
        do_mem(MEM_ST_W, 32'h80, 32'h1234_5678, 5'd0, 1'b0);
        drain();
        check("ex_cause", ECODE_ALE, ex_cause);
        check("ex_badv", 32'h41, ex_badv);
        memory_matches();
        end_test();
    endtask

    task automatic backpressure_test();
        logic [31:0] a;
        test_name = "backpressure";
        bp_mode = 1'b1;
        for (int i = 0; i < 20; i++) begin
            a = 32'h300 + ($random(seed) & 32'hfc);
            case (i % 4)
                0: do_alu(alu_op_t'(i % 10), $random(seed), $random(seed), 5'(i + 1), 1'b1);
                1: begin
                    if (i % 8 == 1)
                        do_mem(MEM_ST_W, a, $random(seed), 5'd0, 1'b1);
                    else
                        do_mem(MEM_ST_B, a + 32'((i >> 2) & 3), $random(seed), 5'd0, 1'b1);
                end
                2: do_mem(MEM_LD_W, a, 0, 5'(i + 1), 1'b1);
                default: do_alu(ALU_MUL, $random(seed), $random(seed), 5'(i + 1), 1'b1);
            endcase
        end
        drain();
        bp_mode = 1'b0;
        end_test();
    endtask

    task automatic counter_test();
        test_name = "counter";
        for (int i = 0; i < 3; i++) begin
            exp_q.push_back('{next_pc, 1'b1, 5'(i + 10), 32'h0, 1'b0, i == 2});
            send(ALU_ADD, 0, 0, 0, MEM_NONE, i == 2 ? CNT_HI : CNT_LO, 1'b1, 5'(i + 10));
        end
        drain();
        if (drained.size() == 3)
            check("cnt_lo increasing", 1, drained[1] > drained[0]);
        end_test();
    endtask

    initial begin
        resetn = 1'b0;
        ds2es_valid = 1'b0;
        ds2es_pc = '0;
        ds2es_alu_op = ALU_ADD;
        ds2es_src1 = '0;
        ds2es_src2 = '0;
        ds2es_store_data = '0;
        ds2es_mem_op = MEM_NONE;
        ds2es_cnt_sel = CNT_ALU;
        ds2es_rf_we = 1'b0;
        ds2es_rf_waddr = '0;
        data_sram_addr_ok = 1'b0;
        data_sram_data_ok = 1'b0;
        data_sram_rdata = '0;
        ws_allowin = 1'b1;
        next_pc = 32'h1c00_0000;
        for (int a = 0; a < 1024; a++) begin
            model_b[a] = 8'(a * 37) ^ 8'(a >> 8);
            ram[a / 4][8 * (a % 4) +: 8] = model_b[a];
        end
        repeat (10) @(posedge clk);
        #1;
        resetn = 1'b1;
        alu_test();
        store_load_test();
        misalign_test();
        backpressure_test();
        counter_test();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== vlog.f ====
common/exe_pkg.sv
common/es_ms_if.sv
exe/alu.sv
exe/exe_stage.sv
rtl/mem_stage.sv
rtl/csr_block.sv
rtl/exe_top.sv
testbench/exe_assertions.sv
testbench/exe_tb.sv
